// File: Makefile
# Verilator build and run for the ping-pong buffer testbench

SIM      = verilator
TOP      = tb_pingpong_buffer
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FLAGS    = --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
FAIL_MSG = SOME TESTS FAILED
PASS_MSG = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim.f
src/pp_pkg.sv
src/pp_sram.sv
src/pp_fill_ctrl.sv
src/pp_bank_pair.sv
src/pp_conv_reader.sv
src/pingpong_buffer_top.sv
tb/tb_pingpong_buffer.sv

// File: src/pingpong_buffer_top.sv
// top of the ping-pong input buffer, wires fill control, bank pair and conv reader on one clock
`timescale 1ns/1ps

module pingpong_buffer_top
  import pp_pkg::*;
#(
  parameter int DP = 768  // words per bank
) (
  input  logic              i_clk_input,
  input  logic              i_rst_n,
  input  logic              i_en,               // chip enable, both sides
  input  logic              i_switch_pingpong,  // level, bank under fill
  input  logic [DATA_W-1:0] i_data_din,
  input  logic              i_data_din_vld,
  output logic              o_pl_buffer_ready,  // fill complete pulse
  input  logic              i_conv_rd,
  input  logic [ADDR_W-1:0] i_conv_addr,
  output logic [DATA_W-1:0] o_conv_dout,
  output logic              o_conv_dout_vld
);

  pp_wr_req_t        wr_req;     // fill side to banks
  pp_rd_req_t        rd_req;     // conv side to banks
  bank_e             fill_bank;
  logic [DATA_W-1:0] rd_data;

  pp_fill_ctrl #(.DP(DP)) u_fill_ctrl (
    .i_clk_input       (i_clk_input),
    .i_rst_n           (i_rst_n),
    .i_en              (i_en),
    .i_switch_pingpong (i_switch_pingpong),
    .i_data_din        (i_data_din),
    .i_data_din_vld    (i_data_din_vld),
    .o_wr_req          (wr_req),
    .o_fill_bank       (fill_bank),
    .o_pl_buffer_ready (o_pl_buffer_ready)
  );

  pp_bank_pair #(.DP(DP)) u_bank_pair (
    .i_clk_input (i_clk_input),
    .i_wr_req    (wr_req),
    .i_rd_req    (rd_req),
    .o_rd_data   (rd_data)
  );

  pp_conv_reader #(.DP(DP)) u_conv_reader (
    .i_clk_input     (i_clk_input),
    .i_rst_n         (i_rst_n),
    .i_en            (i_en),
    .i_fill_bank     (fill_bank),
    .i_conv_rd       (i_conv_rd),
    .i_conv_addr     (i_conv_addr),
    .o_rd_req        (rd_req),
    .i_rd_data       (rd_data),
    .o_conv_dout     (o_conv_dout),
    .o_conv_dout_vld (o_conv_dout_vld)
  );

endmodule

// File: src/pp_bank_pair.sv
// two SRAM banks of the ping-pong buffer, steers write and read requests and returns the read bank's word
`timescale 1ns/1ps

module pp_bank_pair
  import pp_pkg::*;
#(
  parameter int DP = 768  // depth of each bank
) (
  input  logic              i_clk_input,
  input  pp_wr_req_t        i_wr_req,   // from fill ctrl
  input  pp_rd_req_t        i_rd_req,   // from conv reader, registered
  output logic [DATA_W-1:0] o_rd_data   // one cycle after rd_req
);

  logic [DATA_W-1:0] bank_dout [2];  // registered sram outputs
  bank_e             rd_bank_q;      // bank read last edge

  ////////////////////////////////////////////////////////////
  // per bank steering
  ////////////////////////////////////////////////////////////
  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic              wr_hit;  // write aimed here
    logic              rd_hit;  // in-range read aimed here
    logic [ADDR_W-1:0] addr;

    assign wr_hit = i_wr_req.we && (i_wr_req.bank == bank_e'(b));
    assign rd_hit = i_rd_req.rd && i_rd_req.in_range && (i_rd_req.bank == bank_e'(b));
    assign addr   = wr_hit ? i_wr_req.addr : i_rd_req.addr;  // write wins the port

    pp_sram #(
      .DEPTH (DP)
    ) u_sram (
      .i_clk_input (i_clk_input),
      .i_cs        (wr_hit || rd_hit),
      .i_we        (wr_hit),
      .i_addr      (addr),
      .i_din       (i_wr_req.data),
      .o_dout      (bank_dout[b])
    );
  end

  ////////////////////////////////////////////////////////////
  // read data select
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk_input) begin
    rd_bank_q <= i_rd_req.bank;  // lines up with sram output register
  end

  assign o_rd_data = (rd_bank_q == BANK_1) ? bank_dout[1] : bank_dout[0];

  // fill and conv sides must stay on opposite banks, a read must not straddle a switch
  a_no_bank_clash: assert property (@(posedge i_clk_input)
    !(i_wr_req.we && i_rd_req.rd && (i_wr_req.bank == i_rd_req.bank)))
    else $error("pp_bank_pair: write and read on bank %0d together", i_wr_req.bank);

endmodule

// File: src/pp_conv_reader.sv
// output side of the ping-pong buffer, issues conv reads to the idle bank and returns data with a valid
`timescale 1ns/1ps

module pp_conv_reader
  import pp_pkg::*;
#(
  parameter int DP = 768  // words per bank
) (
  input  logic              i_clk_input,
  input  logic              i_rst_n,
  input  logic              i_en,             // chip enable
  input  bank_e             i_fill_bank,      // bank under fill
  input  logic              i_conv_rd,        // read strobe
  input  logic [ADDR_W-1:0] i_conv_addr,
  output pp_rd_req_t        o_rd_req,         // to bank pair
  input  logic [DATA_W-1:0] i_rd_data,        // from bank pair
  output logic [DATA_W-1:0] o_conv_dout,
  output logic              o_conv_dout_vld   // two edges after strobe
);

  localparam logic [ADDR_W:0] DP_LIM = (ADDR_W + 1)'(DP);

  logic              rd_issue;   // strobe accepted
  logic              rd_vld_q;   // stage 1, sram read next edge
  bank_e             rd_bank_q;
  logic              rd_inr_q;
  logic [ADDR_W-1:0] rd_addr_q;
  logic              vld_s2;     // stage 2, data on i_rd_data
  logic              inr_s2;

  assign rd_issue = i_conv_rd && i_en;

  ////////////////////////////////////////////////////////////
  // stage 1, request register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk_input) begin
    if (!i_rst_n) begin
      rd_vld_q  <= 1'b0;
      rd_bank_q <= BANK_1;
      rd_inr_q  <= 1'b0;
    end else begin
      rd_vld_q <= rd_issue;
      if (rd_issue) begin
        rd_bank_q <= (i_fill_bank == BANK_0) ? BANK_1 : BANK_0;  // idle bank
        rd_inr_q  <= ({1'b0, i_conv_addr} < DP_LIM);            // range check
      end
    end
  end

  always_ff @(posedge i_clk_input) begin
    if (rd_issue) begin
      rd_addr_q <= i_conv_addr;  // payload
    end
  end

  assign o_rd_req.rd       = rd_vld_q;
  assign o_rd_req.bank     = rd_bank_q;
  assign o_rd_req.addr     = rd_addr_q;
  assign o_rd_req.in_range = rd_inr_q;

  ////////////////////////////////////////////////////////////
  // stage 2 and output
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk_input) begin
    if (!i_rst_n) begin
      vld_s2          <= 1'b0;
      inr_s2          <= 1'b0;
      o_conv_dout_vld <= 1'b0;
      o_conv_dout     <= '0;
    end else begin
      vld_s2          <= rd_vld_q;
      inr_s2          <= rd_inr_q;
      o_conv_dout_vld <= vld_s2;
      if (vld_s2) begin
        o_conv_dout <= inr_s2 ? i_rd_data : '0;  // out of range reads zero
      end
    end
  end

  // whole read path through the bank pair is a fixed three-register pipe
  a_vld_latency: assert property (@(posedge i_clk_input) disable iff (!i_rst_n)
    ($past(i_rst_n, 1) && $past(i_rst_n, 2) && $past(i_rst_n, 3))
      |-> (o_conv_dout_vld == $past(rd_issue, 3)))
    else $error("pp_conv_reader: dout valid out of step with read strobe");

endmodule

// File: src/pp_fill_ctrl.sv
// input side of the ping-pong buffer, follows the switch level and turns the byte stream into bank writes
`timescale 1ns/1ps

module pp_fill_ctrl
  import pp_pkg::*;
#(
  parameter int DP = 768  // words per fill
) (
  input  logic              i_clk_input,
  input  logic              i_rst_n,
  input  logic              i_en,               // chip enable
  input  logic              i_switch_pingpong,  // level, names fill bank
  input  logic [DATA_W-1:0] i_data_din,
  input  logic              i_data_din_vld,
  output pp_wr_req_t        o_wr_req,           // to bank pair, same cycle
  output bank_e             o_fill_bank,        // to conv reader
  output logic              o_pl_buffer_ready   // one cycle after DP-th write
);

  localparam int CNT_W = ADDR_W + 1;                   // room to hold DP itself
  localparam logic [CNT_W-1:0] DP_CNT = CNT_W'(DP);

  bank_e            fill_bank_q;  // bank under fill
  bank_e            sw_bank;      // bank named by the switch level
  logic [CNT_W-1:0] wr_cnt_q;     // accepted writes this fill
  logic             ready_q;
  logic             sw_change;    // level differs from held bank
  logic             wr_accept;

  ////////////////////////////////////////////////////////////
  // acceptance
  ////////////////////////////////////////////////////////////
  assign sw_bank   = i_switch_pingpong ? BANK_1 : BANK_0;
  assign sw_change = (sw_bank != fill_bank_q);
  assign wr_accept = i_en && i_data_din_vld && (wr_cnt_q < DP_CNT);  // extra bytes dropped

  // write goes out this cycle, old bank, addr = count
  assign o_wr_req.we   = wr_accept;
  assign o_wr_req.bank = fill_bank_q;
  assign o_wr_req.addr = wr_cnt_q[ADDR_W-1:0];
  assign o_wr_req.data = i_data_din;

  ////////////////////////////////////////////////////////////
  // bank level, fill count, ready
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk_input) begin
    if (!i_rst_n) begin
      fill_bank_q <= BANK_0;
      wr_cnt_q    <= '0;
      ready_q     <= 1'b0;
    end else begin
      fill_bank_q <= sw_bank;                                    // one cycle behind the level
      ready_q     <= wr_accept && (wr_cnt_q == DP_CNT - 1'b1);   // DP-th write
      if (sw_change) begin
        wr_cnt_q <= '0;                                          // roles swap, new fill
      end else if (wr_accept) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end
    end
  end

  assign o_fill_bank       = fill_bank_q;
  assign o_pl_buffer_ready = ready_q;

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////
  a_wr_addr_below_dp: assert property (@(posedge i_clk_input) disable iff (!i_rst_n)
    o_wr_req.we |-> (o_wr_req.addr < DP))
    else $error("pp_fill_ctrl: write addr %0d not below DP", o_wr_req.addr);

  // a fill completes at most once, so ready can never repeat on the next cycle
  a_ready_single: assert property (@(posedge i_clk_input) disable iff (!i_rst_n)
    o_pl_buffer_ready |=> !o_pl_buffer_ready)
    else $error("pp_fill_ctrl: ready held for two cycles");

endmodule

// File: src/pp_pkg.sv
// shared widths, bank select and request structs for the ping-pong buffer, imported by every RTL block
package pp_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////
  localparam int DATA_W = 8;   // one pixel byte
  localparam int ADDR_W = 10;  // bank address, DP up to 1024

  ////////////////////////////////////////////////////////////
  // bank select
  ////////////////////////////////////////////////////////////
  typedef enum logic {
    BANK_0 = 1'b0,  // sram 0
    BANK_1 = 1'b1   // sram 1
  } bank_e;

  // write side request, built combinationally by the fill controller
  typedef struct packed {
    logic              we;    // write strobe
    bank_e             bank;  // bank being filled
    logic [ADDR_W-1:0] addr;  // fill count
    logic [DATA_W-1:0] data;  // pixel byte
  } pp_wr_req_t;

  // read side request, registered by the conv reader
  typedef struct packed {
    logic              rd;        // read strobe
    bank_e             bank;      // bank to read
    logic [ADDR_W-1:0] addr;      // conv address
    logic              in_range;  // addr below DP
  } pp_rd_req_t;

endpackage

// File: src/pp_sram.sv
// single-port synchronous byte SRAM bank, instantiated twice by pp_bank_pair
`timescale 1ns/1ps

module pp_sram
  import pp_pkg::*;
#(
  parameter int DEPTH = 768  // words in this bank
) (
  input  logic              i_clk_input,
  input  logic              i_cs,         // chip select
  input  logic              i_we,         // 1 write, 0 read
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [DATA_W-1:0] i_din,
  output logic [DATA_W-1:0] o_dout        // registered read word
);

  logic [DATA_W-1:0] mem [DEPTH];  // storage, undefined until written

  always_ff @(posedge i_clk_input) begin
    if (i_cs && i_we) begin
      mem[i_addr] <= i_din;   // write port
    end else if (i_cs) begin
      o_dout <= mem[i_addr];  // read, one cycle latency
    end
  end

  // callers must range-check before selecting the bank
  a_addr_in_depth: assert property (@(posedge i_clk_input)
    i_cs |-> (i_addr < DEPTH))
    else $error("pp_sram: access at addr %0d beyond depth %0d", i_addr, DEPTH);

endmodule

// File: tb/tb_pingpong_buffer.sv
// self-checking testbench for pingpong_buffer_top, compiled from the file list with this module as top
`timescale 1ns/1ps

module tb_pingpong_buffer;

  localparam int DP = 768;

  typedef struct packed {
    logic [31:0] due;   // cycle the valid should be seen
    logic [7:0]  data;  // expected byte
  } exp_rd_t;

  logic        clk_input = 1'b0;
  logic        rst_n;
  logic        en;
  logic        switch_pingpong;
  logic [7:0]  data_din;
  logic        data_din_vld;
  logic        pl_buffer_ready;
  logic        conv_rd;
  logic [9:0]  conv_addr;
  logic [7:0]  conv_dout;
  logic        conv_dout_vld;

  logic [15:0] lfsr = 16'd45404;
  logic [7:0]  model_mem [2][1024];     // reference copy of both banks
  logic        model_bank = 1'b0;       // bank under fill
  int          model_cnt = 0;           // accepted writes this fill
  int unsigned cyc = 0;
  int unsigned ready_due = 32'hffff_ffff;
  exp_rd_t     exp_q [$];               // reads in flight
  int          err_cnt = 0;
  int          rdy_pulses = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic        chk_pend = 1'b0;         // compare points, one edge behind the DUT
  logic [7:0]  chk_exp = '0;
  logic [7:0]  chk_act = '0;
  logic [31:0] chk_due = '0;
  logic [31:0] chk_cyc = '0;
  logic        spurious = 1'b0;
  logic        late = 1'b0;
  logic        rdy_act = 1'b0;
  logic        rdy_exp = 1'b0;

  pingpong_buffer_top #(.DP(DP)) i_dut (
    .i_clk_input (clk_input), .i_rst_n (rst_n), .i_en (en),
    .i_switch_pingpong (switch_pingpong), .i_data_din (data_din),
    .i_data_din_vld (data_din_vld), .o_pl_buffer_ready (pl_buffer_ready),
    .i_conv_rd (conv_rd), .i_conv_addr (conv_addr),
    .o_conv_dout (conv_dout), .o_conv_dout_vld (conv_dout_vld)
  );

  always #20 clk_input = ~clk_input;  // 40 ns period

  always @(posedge clk_input) begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////////////////////////
  // random source and stimulus
  ////////////////////////////////////////////////////////////
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // one clock of stimulus, model follows the acceptance rule
  task automatic step(input logic en_v, input logic vld_v, input logic [7:0] din_v,
                      input logic rd_v, input logic [9:0] addr_v);
    exp_rd_t e;
    @(posedge clk_input);
    en           <= en_v;
    data_din_vld <= vld_v;
    data_din     <= din_v;
    conv_rd      <= rd_v;
    conv_addr    <= addr_v;
    if (en_v && vld_v && model_cnt < DP) begin
      model_mem[model_bank][model_cnt] = din_v;
      model_cnt++;
      if (model_cnt == DP) begin
        ready_due = cyc + 2;  // pulse after the DP-th write
      end
    end
    if (en_v && rd_v) begin
      e.due  = cyc + 4;  // sampled next edge, valid two edges later
      e.data = (addr_v < DP) ? model_mem[!model_bank][addr_v] : 8'h00;
      exp_q.push_back(e);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) step(1'b1, 1'b0, 8'h00, 1'b0, 10'd0);
  endtask

  task automatic drain_reads();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 32) begin
      idle(1);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout at %0t: %0d reads never got o_conv_dout_vld", $time, exp_q.size());
      err_cnt++;
    end
    idle(3);  // last compare lands
  endtask

  task automatic switch_bank(input logic lvl);
    drain_reads();
    switch_pingpong <= lvl;  // same edge as the last idle step
    model_bank = lvl;
    model_cnt  = 0;
    idle(3);
  endtask

  // random bytes with gaps, en low for 40 cycles from en_gap_at
  task automatic fill_bank_rand(input logic with_reads, input int en_gap_at);
    int          n;
    logic        en_v;
    logic        vld_v;
    logic        rd_v;
    logic [7:0]  din_v;
    logic [9:0]  addr_v;
    n = 0;
    while (model_cnt < DP && n < 6 * DP) begin
      en_v   = !(n >= en_gap_at && n < en_gap_at + 40);
      vld_v  = (take_bits(2) != 0);
      din_v  = 8'(take_bits(8));
      rd_v   = with_reads && take_bits(1);
      addr_v = 10'(take_bits(10) % DP);
      step(en_v, vld_v, din_v, rd_v, addr_v);
      n++;
    end
    if (model_cnt < DP) begin
      $display("timeout at %0t: fill stopped at %0d of %0d writes", $time, model_cnt, DP);
      err_cnt++;
    end
  endtask

  task automatic read_rand(input int n, input int base, input int span);
    logic       rd_v;
    logic [9:0] addr_v;
    for (int i = 0; i < n; i++) begin
      rd_v   = (take_bits(2) != 0);  // mostly back to back
      addr_v = 10'(base + take_bits(10) % span);
      step(1'b1, 1'b0, 8'h00, rd_v, addr_v);
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (err_cnt == err_before) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // response capture and checks
  ////////////////////////////////////////////////////////////
  always @(posedge clk_input) begin
    exp_rd_t head;
    chk_pend <= 1'b0;
    spurious <= 1'b0;
    late     <= 1'b0;
    if (conv_dout_vld) begin
      if (exp_q.size() == 0) begin
        spurious <= 1'b1;
      end else begin
        head = exp_q.pop_front();
        chk_pend <= 1'b1;
        chk_exp  <= head.data;
        chk_due  <= head.due;
        chk_act  <= conv_dout;
        chk_cyc  <= cyc;
      end
    end else if (exp_q.size() != 0 && exp_q[0].due < cyc) begin
      late <= 1'b1;
      void'(exp_q.pop_front());  // drop it, reported once
    end
    if (pl_buffer_ready) begin
      rdy_pulses++;
    end
    rdy_act <= pl_buffer_ready;
    rdy_exp <= (cyc == ready_due);
  end

  a_dout_value: assert property (@(posedge clk_input) chk_pend |-> (chk_act == chk_exp))
    else begin
      $display("FAILED at %0t: o_conv_dout expected 0x%02h got 0x%02h",
               $time, $sampled(chk_exp), $sampled(chk_act));
      err_cnt++;
    end

  a_vld_timing: assert property (@(posedge clk_input) chk_pend |-> (chk_cyc == chk_due))
    else begin
      $display("FAILED at %0t: o_conv_dout_vld cycle expected %0d got %0d",
               $time, $sampled(chk_due), $sampled(chk_cyc));
      err_cnt++;
    end

  a_no_spurious: assert property (@(posedge clk_input) !spurious)
    else begin
      $display("error at %0t: o_conv_dout_vld high with no read outstanding", $time);
      err_cnt++;
    end

  a_no_late: assert property (@(posedge clk_input) !late)
    else begin
      $display("error at %0t: a read strobe never produced o_conv_dout_vld", $time);
      err_cnt++;
    end

  a_ready_timing: assert property (@(posedge clk_input) disable iff (!rst_n)
    rdy_act == rdy_exp)
    else begin
      $display("FAILED at %0t: o_pl_buffer_ready expected %0b got %0b",
               $time, $sampled(rdy_exp), $sampled(rdy_act));
      err_cnt++;
    end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int e0;
    rst_n           = 1'b0;
    en              = 1'b0;
    switch_pingpong = 1'b0;
    data_din        = '0;
    data_din_vld    = 1'b0;
    conv_rd         = 1'b0;
    conv_addr       = '0;
    repeat (2) @(posedge clk_input);
    rst_n <= 1'b1;

    e0 = err_cnt;
    idle(10);
    a_dout_reset: assert (conv_dout == 8'h00)
      else begin
        $display("FAILED at %0t: o_conv_dout expected 0x00 got 0x%02h", $time, conv_dout);
        err_cnt++;
      end
    finish_test("idle after reset", e0);

    e0 = err_cnt;
    rdy_pulses = 0;
    fill_bank_rand(1'b0, 200);
    repeat (16) step(1'b1, 1'b1, 8'(take_bits(8)), 1'b0, 10'd0);  // overflow bytes
    idle(4);
    a_one_ready_0: assert (rdy_pulses == 1)
      else begin
        $display("error at %0t: ready pulsed %0d times on the bank 0 fill", $time, rdy_pulses);
        err_cnt++;
      end
    finish_test("fill bank 0", e0);

    e0 = err_cnt;
    switch_bank(1'b1);
    read_rand(200, 0, DP);
    drain_reads();
    finish_test("read bank 0", e0);

    e0 = err_cnt;
    rdy_pulses = 0;
    fill_bank_rand(1'b1, 1 << 30);  // reads of bank 0 interleaved
    drain_reads();
    a_one_ready_1: assert (rdy_pulses == 1)
      else begin
        $display("error at %0t: ready pulsed %0d times on the bank 1 fill", $time, rdy_pulses);
        err_cnt++;
      end
    finish_test("fill bank 1 while reading bank 0", e0);

    e0 = err_cnt;
    read_rand(60, DP, 1024 - DP);
    step(1'b1, 1'b0, 8'h00, 1'b1, 10'(DP));
    step(1'b1, 1'b0, 8'h00, 1'b1, 10'd1023);
    repeat (8) step(1'b0, 1'b0, 8'h00, 1'b1, 10'(take_bits(10) % DP));  // en low, no valid
    drain_reads();
    finish_test("out of range and disabled reads", e0);

    e0 = err_cnt;
    switch_bank(1'b0);
    read_rand(150, 0, DP);
    drain_reads();
    repeat (48) step(1'b1, 1'b1, 8'(take_bits(8)), 1'b0, 10'd0);  // partial refill of bank 0
    switch_bank(1'b1);
    for (int i = 0; i < 64; i++) begin
      step(1'b1, 1'b0, 8'h00, 1'b1, 10'(i));  // new bytes, then old ones
    end
    drain_reads();
    finish_test("swap back and refill bank 0", e0);

    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
